// ==== hdl/seqPkg.sv ====
`default_nettype none

package seqPkg;

	////////////////////////////////////////
	// Widths and constants
	////////////////////////////////////////
	localparam int ADDR_W     = 16;
	localparam int DATA_W     = 32;
	localparam int DELAY_TRIM = 4;	// Cycles eaten by fetch and decode

	// Instruction opcodes
	typedef enum logic [7:0] {
		PP_NOP     = 8'h00,
		PP_LDWR    = 8'h01,	// W = mem[addr]
		PP_LDWI    = 8'h03,	// W = mem[I]
		PP_STWR    = 8'h04,	// mem[addr] = W
		PP_STWI    = 8'h05,	// mem[I] = W
		PP_LDINDF  = 8'h06,	// I = mem[addr]
		PP_STINDF  = 8'h07,	// mem[addr] = I
		PP_CLRW    = 8'h08,
		PP_CMP     = 8'h09,
		PP_CMPI    = 8'h0a,
		PP_JMP     = 8'h10,
		PP_JMPZ    = 8'h11,
		PP_JMPNZ   = 8'h12,
		PP_JMPG    = 8'h13,
		PP_JMPL    = 8'h14,
		PP_JMPGE   = 8'h15,
		PP_JMPLE   = 8'h16,
		PP_ANDW    = 8'h17,
		PP_ADDW    = 8'h19,
		PP_ADDI    = 8'h21,
		PP_INC     = 8'h23,
		PP_INCI    = 8'h24,
		PP_DEC     = 8'h25,
		PP_DECI    = 8'h26,
		PP_SUB     = 8'h29,
		PP_SUBI    = 8'h31,
		PP_SHL     = 8'h33,
		PP_SHR     = 8'h35,
		PP_DELAY   = 8'h42,
		PP_WAITL   = 8'h44,
		PP_COUNT   = 8'h45,
		PP_SHUTTER = 8'h52,
		PP_STOP    = 8'hFF
	} opcode_e;

	// Compare result, unknown until the first CMP
	typedef enum logic [1:0] {CF_EQ = 2'h0, CF_G = 2'h1, CF_L = 2'h2, CF_UNK = 2'h3} cmpFlag_e;

	////////////////////////////////////////
	// State codes
	////////////////////////////////////////
	typedef enum logic {RUN_IDLE, RUN_ACTIVE} runState_e;
	typedef enum logic [1:0] {EX_IDLE, EX_EXEC, EX_WAIT} execState_e;
	typedef enum logic [1:0] {WAIT_DELAY, WAIT_LINE, WAIT_COUNT} waitKind_e;

	// Two views of one instruction word
	typedef struct packed {
		opcode_e           op;
		logic [7:0]        reserved;
		logic [ADDR_W-1:0] addr;
	} instrAddr_t;

	typedef struct packed {
		opcode_e     op;
		logic        direct;	// Set when value is the operand itself
		logic [22:0] value;
	} instrDirect_t;

	typedef union packed {
		instrAddr_t   a;
		instrDirect_t d;
	} instrWord_t;

	typedef struct packed {
		logic              re;
		logic              we;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wrData;
	} memReq_t;

endpackage

`default_nettype wire

// ==== hdl/memArbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module memArbiter import seqPkg::*; (
	input  logic              wClk_i,
	input  logic              rst_i,
	input  memReq_t           fetchReq_i,
	input  memReq_t           execReq_i,
	input  logic [DATA_W-1:0] memRdData_i,
	output logic              fetchGrant_o,
	output logic              fetchDataValid_o,
	output logic              execDataValid_o,
	output logic [DATA_W-1:0] rdData_o,
	output logic [ADDR_W-1:0] memAddr_o,
	output logic [DATA_W-1:0] memWrData_o,
	output logic              memWe_o
);

	logic    execOwns;
	memReq_t portReq;

	assign execOwns     = execReq_i.re | execReq_i.we;	// Execute always wins
	assign portReq      = execOwns ? execReq_i : fetchReq_i;
	assign fetchGrant_o = fetchReq_i.re & ~execOwns;

	assign memAddr_o   = portReq.addr;
	assign memWrData_o = portReq.wrData;
	assign memWe_o     = portReq.we;
	assign rdData_o    = memRdData_i;

	// Owner of the read in flight
	always_ff @(posedge wClk_i)
	begin
		if (rst_i)
		begin
			fetchDataValid_o <= 1'b0;
			execDataValid_o  <= 1'b0;
		end
		else
		begin
			fetchDataValid_o <= fetchGrant_o;
			execDataValid_o  <= execOwns & execReq_i.re;
		end
	end

	// A fetch read cycle never carries a write
	assert property (@(posedge wClk_i) disable iff (rst_i) fetchDataValid_o |-> !$past(memWe_o))
		else $error("memArbiter: write issued on a fetch read cycle");

endmodule

`default_nettype wire

// ==== hdl/fetchUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetchUnit import seqPkg::*; #(
	parameter logic [ADDR_W-1:0] START_ADDR_RESET = 16'hFFFF
) (
	input  logic              wClk_i,
	input  logic              rst_i,
	input  logic [ADDR_W-1:0] startAddr_i,
	input  logic              startTrig_i,
	input  logic              stopTrig_i,
	input  logic              stopExec_i,
	input  logic              fetchGrant_i,
	input  logic              fetchDataValid_i,
	input  logic [DATA_W-1:0] rdData_i,
	input  logic              instrTake_i,
	input  logic              redirect_i,
	input  logic [ADDR_W-1:0] redirectAddr_i,
	output memReq_t           fetchReq_o,
	output instrWord_t        instr_o,
	output logic              instrValid_o,
	output logic              busy_o
);

	runState_e         runState;
	logic [ADDR_W-1:0] pc;
	logic              dropRd;	// Read issued alongside a redirect
	logic              loadWord;
	instrWord_t        instrBuf;

	assign busy_o   = (runState == RUN_ACTIVE);
	assign loadWord = fetchDataValid_i & ~dropRd & busy_o;
	assign instr_o  = instrBuf;

	// Prefetch as soon as the buffer is free or being taken
	assign fetchReq_o.re     = busy_o & (~instrValid_o | instrTake_i) & ~fetchDataValid_i;
	assign fetchReq_o.we     = 1'b0;
	assign fetchReq_o.addr   = pc;
	assign fetchReq_o.wrData = '0;

	////////////////////////////////////////
	// Run state and program counter
	////////////////////////////////////////
	always_ff @(posedge wClk_i)
	begin
		if (rst_i)
		begin
			runState     <= RUN_IDLE;
			pc           <= START_ADDR_RESET;
			instrValid_o <= 1'b0;
			dropRd       <= 1'b0;
		end
		else
		begin
			dropRd <= redirect_i & fetchGrant_i;

			if (instrTake_i)
				instrValid_o <= 1'b0;
			if (loadWord)
				instrValid_o <= 1'b1;

			if (redirect_i)
				pc <= redirectAddr_i;	// Jump target
			else if (fetchGrant_i)
				pc <= pc + ADDR_W'(1);

			case (runState)
				RUN_IDLE:
					if (startTrig_i)
					begin
						runState <= RUN_ACTIVE;
						pc       <= startAddr_i;
					end
				default:
					if (stopTrig_i | stopExec_i)
					begin
						runState     <= RUN_IDLE;
						instrValid_o <= 1'b0;
					end
			endcase
		end
	end

	always_ff @(posedge wClk_i)
	begin
		if (loadWord)
			instrBuf <= rdData_i;
	end

	// Nothing stays presented once the run has stopped
	assert property (@(posedge wClk_i) disable iff (rst_i) instrValid_o |-> busy_o)
		else $error("fetchUnit: instruction presented while idle");

endmodule

`default_nettype wire

// ==== hdl/execUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module execUnit import seqPkg::*; (
	input  logic              wClk_i,
	input  logic              rst_i,
	input  instrWord_t        instr_i,
	input  logic              instrValid_i,
	input  logic              execDataValid_i,
	input  logic [DATA_W-1:0] rdData_i,
	input  logic              waitBusy_i,
	input  logic              countDone_i,
	input  logic [DATA_W-1:0] photonCount_i,
	output memReq_t           execReq_o,
	output logic              instrTake_o,
	output logic              redirect_o,
	output logic [ADDR_W-1:0] redirectAddr_o,
	output logic              stopExec_o,
	output logic              waitStart_o,
	output waitKind_e         waitKind_o,
	output logic [DATA_W-1:0] waitCount_o,
	output logic [7:0]        shutter_o
);

	////////////////////////////////////////
	// Decode helpers
	////////////////////////////////////////
	function automatic logic readsOperand(input opcode_e op);
		return op inside {PP_LDWR, PP_LDWI, PP_LDINDF, PP_CMP, PP_CMPI, PP_ANDW, PP_ADDW,
			PP_ADDI, PP_SUB, PP_SUBI, PP_SHL, PP_SHR, PP_DELAY, PP_COUNT, PP_SHUTTER};
	endfunction

	function automatic logic runsAlu(input opcode_e op);
		return readsOperand(op) ||
			(op inside {PP_CLRW, PP_INC, PP_DEC, PP_INCI, PP_DECI, PP_WAITL});
	endfunction

	function automatic logic jumpTaken(input opcode_e op, input cmpFlag_e flag);
		case (op)
			PP_JMP:   return 1'b1;
			PP_JMPZ:  return flag == CF_EQ;
			PP_JMPNZ: return flag == CF_G || flag == CF_L;	// Unknown flag never jumps
			PP_JMPG:  return flag == CF_G;
			PP_JMPL:  return flag == CF_L;
			PP_JMPGE: return flag == CF_EQ || flag == CF_G;
			PP_JMPLE: return flag == CF_EQ || flag == CF_L;
			default:  return 1'b0;
		endcase
	endfunction

	function automatic cmpFlag_e compare(input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
		return (a > b) ? CF_G : ((a < b) ? CF_L : CF_EQ);
	endfunction

	execState_e        state;
	instrWord_t        cmdReg;
	opcode_e           takeOp;
	opcode_e           curOp;
	logic [DATA_W-1:0] wReg;
	logic [ADDR_W-1:0] iReg;
	cmpFlag_e          cmpFlag;
	logic [DATA_W-1:0] operand;
	logic              isWait;

	assign takeOp = instr_i.a.op;
	assign curOp  = cmdReg.a.op;

	// Jumps, stores and STOP finish in the take cycle
	assign instrTake_o    = (state == EX_IDLE) & instrValid_i;
	assign redirect_o     = instrTake_o & jumpTaken(takeOp, cmpFlag);
	assign redirectAddr_o = instr_i.a.addr;
	assign stopExec_o     = instrTake_o & (takeOp == PP_STOP);

	assign execReq_o.re     = instrTake_o & readsOperand(takeOp) & ~instr_i.d.direct;
	assign execReq_o.we     = instrTake_o & (takeOp inside {PP_STWR, PP_STWI, PP_STINDF});
	assign execReq_o.addr   = (takeOp == PP_LDWI || takeOp == PP_STWI) ? iReg : instr_i.a.addr;
	assign execReq_o.wrData = (takeOp == PP_STINDF) ? DATA_W'(iReg) : wReg;

	// Memory word if one was read, else the direct value
	assign operand = execDataValid_i ? rdData_i : DATA_W'(cmdReg.d.value);
	assign isWait  = curOp inside {PP_DELAY, PP_WAITL, PP_COUNT};

	assign waitStart_o = (state == EX_EXEC) & isWait;
	assign waitCount_o = operand;

	always_comb
	begin
		case (curOp)
			PP_WAITL: waitKind_o = WAIT_LINE;
			PP_COUNT: waitKind_o = WAIT_COUNT;
			default:  waitKind_o = WAIT_DELAY;
		endcase
	end

	always_ff @(posedge wClk_i)
	begin
		if (instrTake_o)
			cmdReg <= instr_i;
	end

	always_ff @(posedge wClk_i)
	begin
		if (rst_i)
		begin
			state     <= EX_IDLE;
			wReg      <= '0;
			iReg      <= '0;
			cmpFlag   <= CF_UNK;
			shutter_o <= 8'h00;
		end
		else
		begin
			case (state)
				EX_IDLE:
					if (instrTake_o && runsAlu(takeOp))
						state <= EX_EXEC;
				EX_EXEC:
				begin
					state <= isWait ? EX_WAIT : EX_IDLE;
					case (curOp)
						PP_LDWR, PP_LDWI:  wReg <= operand;
						PP_LDINDF:         iReg <= operand[ADDR_W-1:0];
						PP_CLRW, PP_COUNT: wReg <= '0;	// COUNT fills W at the end
						PP_CMP:            cmpFlag <= compare(wReg, operand);
						PP_CMPI:           cmpFlag <= compare(DATA_W'(iReg), DATA_W'(operand[ADDR_W-1:0]));
						PP_ANDW:           wReg <= wReg & operand;
						PP_ADDW:           wReg <= wReg + operand;
						PP_SUB:            wReg <= wReg - operand;
						PP_SHL:            wReg <= wReg << operand;
						PP_SHR:            wReg <= wReg >> operand;
						PP_INC:            wReg <= wReg + DATA_W'(1);
						PP_DEC:            wReg <= wReg - DATA_W'(1);
						PP_ADDI:           iReg <= iReg + operand[ADDR_W-1:0];
						PP_SUBI:           iReg <= iReg - operand[ADDR_W-1:0];
						PP_INCI:           iReg <= iReg + ADDR_W'(1);
						PP_DECI:           iReg <= iReg - ADDR_W'(1);
						PP_SHUTTER:        shutter_o <= operand[7:0];
						default:           ;
					endcase
				end
				EX_WAIT:
				begin
					if (countDone_i)
						wReg <= photonCount_i;
					if (!waitBusy_i)
						state <= EX_IDLE;
				end
				default:
					state <= EX_IDLE;
			endcase
		end
	end

	// No instruction slips past a running wait
	assert property (@(posedge wClk_i) disable iff (rst_i) instrTake_o |-> !waitBusy_i)
		else $error("execUnit: instruction taken during a wait");

endmodule

`default_nettype wire

// ==== hdl/waitUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module waitUnit import seqPkg::*; (
	input  logic              wClk_i,
	input  logic              rst_i,
	input  logic              waitStart_i,
	input  waitKind_e         waitKind_i,
	input  logic [DATA_W-1:0] waitCount_i,
	input  logic              lineTrig_i,
	input  logic              pmt_i,
	output logic              waitBusy_o,
	output logic              countDone_o,
	output logic [DATA_W-1:0] photonCount_o
);

	waitKind_e         kindReg;
	logic [DATA_W-1:0] cnt;
	logic [DATA_W-1:0] acc;
	logic [DATA_W-1:0] delayLoad;
	logic [DATA_W-1:0] startCnt;

	assign delayLoad = (waitCount_i > DATA_W'(DELAY_TRIM)) ? waitCount_i - DATA_W'(DELAY_TRIM) : '0;
	assign startCnt  = (waitKind_i == WAIT_DELAY) ? delayLoad : waitCount_i;
	assign photonCount_o = acc;

	always_ff @(posedge wClk_i)
	begin
		if (rst_i)
		begin
			waitBusy_o  <= 1'b0;
			countDone_o <= 1'b0;
		end
		else
		begin
			countDone_o <= 1'b0;
			if (waitStart_i)
				waitBusy_o <= (waitKind_i == WAIT_LINE) || (startCnt != '0);
			else if (waitBusy_o)
			begin
				if (kindReg == WAIT_LINE)
					waitBusy_o <= ~lineTrig_i;	// First trigger ends it
				else if (cnt == DATA_W'(1))
				begin
					waitBusy_o  <= 1'b0;
					countDone_o <= (kindReg == WAIT_COUNT);
				end
			end
		end
	end

	// Down-counter and photon accumulator
	always_ff @(posedge wClk_i)
	begin
		if (waitStart_i)
		begin
			kindReg <= waitKind_i;
			cnt     <= startCnt;
			acc     <= '0;
		end
		else if (waitBusy_o)
		begin
			cnt <= cnt - DATA_W'(1);
			acc <= acc + DATA_W'(pmt_i);
		end
	end

endmodule

`default_nettype wire

// ==== hdl/seqTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module seqTop import seqPkg::*; #(
	parameter logic [ADDR_W-1:0] START_ADDR_RESET = 16'hFFFF
) (
	input  logic              wClk_i,
	input  logic              rst_i,
	input  logic [ADDR_W-1:0] startAddr_i,
	input  logic              startTrig_i,
	input  logic              stopTrig_i,
	input  logic              lineTrig_i,
	input  logic              pmt_i,
	input  logic [DATA_W-1:0] memRdData_i,
	output logic              busy_o,
	output logic [ADDR_W-1:0] memAddr_o,
	output logic [DATA_W-1:0] memWrData_o,
	output logic              memWe_o,
	output logic [7:0]        shutter_o
);

	memReq_t           fetchReq;
	memReq_t           execReq;
	logic              fetchGrant;
	logic              fetchDataValid;
	logic              execDataValid;
	logic [DATA_W-1:0] rdData;
	instrWord_t        instr;
	logic              instrValid;
	logic              instrTake;
	logic              redirect;
	logic [ADDR_W-1:0] redirectAddr;
	logic              stopExec;
	logic              waitStart;
	waitKind_e         waitKind;
	logic [DATA_W-1:0] waitCount;
	logic              waitBusy;
	logic              countDone;
	logic [DATA_W-1:0] photonCount;

	memArbiter memArbiter_inst (
		.wClk_i(wClk_i), .rst_i(rst_i),
		.fetchReq_i(fetchReq), .execReq_i(execReq), .memRdData_i(memRdData_i),
		.fetchGrant_o(fetchGrant), .fetchDataValid_o(fetchDataValid),
		.execDataValid_o(execDataValid), .rdData_o(rdData),
		.memAddr_o(memAddr_o), .memWrData_o(memWrData_o), .memWe_o(memWe_o)
	);

	fetchUnit #(.START_ADDR_RESET(START_ADDR_RESET)) fetchUnit_inst (
		.wClk_i(wClk_i), .rst_i(rst_i),
		.startAddr_i(startAddr_i), .startTrig_i(startTrig_i), .stopTrig_i(stopTrig_i),
		.stopExec_i(stopExec), .fetchGrant_i(fetchGrant), .fetchDataValid_i(fetchDataValid),
		.rdData_i(rdData), .instrTake_i(instrTake),
		.redirect_i(redirect), .redirectAddr_i(redirectAddr),
		.fetchReq_o(fetchReq), .instr_o(instr), .instrValid_o(instrValid), .busy_o(busy_o)
	);

	execUnit execUnit_inst (
		.wClk_i(wClk_i), .rst_i(rst_i),
		.instr_i(instr), .instrValid_i(instrValid),
		.execDataValid_i(execDataValid), .rdData_i(rdData),
		.waitBusy_i(waitBusy), .countDone_i(countDone), .photonCount_i(photonCount),
		.execReq_o(execReq), .instrTake_o(instrTake),
		.redirect_o(redirect), .redirectAddr_o(redirectAddr), .stopExec_o(stopExec),
		.waitStart_o(waitStart), .waitKind_o(waitKind), .waitCount_o(waitCount),
		.shutter_o(shutter_o)
	);

	waitUnit waitUnit_inst (
		.wClk_i(wClk_i), .rst_i(rst_i),
		.waitStart_i(waitStart), .waitKind_i(waitKind), .waitCount_i(waitCount),
		.lineTrig_i(lineTrig_i), .pmt_i(pmt_i),
		.waitBusy_o(waitBusy), .countDone_o(countDone), .photonCount_o(photonCount)
	);

endmodule

`default_nettype wire

// ==== sim/clockGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
	parameter int HALF_NS = 2	// 4 ns period
) (
	output logic clk_o
);

	initial
	begin
		clk_o = 1'b0;
		forever #(HALF_NS) clk_o = ~clk_o;
	end

endmodule

`default_nettype wire

// ==== sim/seqTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module seqTb;

	localparam logic [15:0] MAIN_START = 16'h0000;
	localparam logic [15:0] HOLD_START = 16'h0080;	// Long DELAY, then STOP
	localparam int          TIMEOUT    = 5000;

	logic        wClk;
	logic        rst;
	logic [15:0] startAddr;
	logic        startTrig;
	logic        stopTrig;
	logic        lineTrig;
	logic        pmt;
	logic [31:0] memRdData;
	logic        busy;
	logic [15:0] memAddr;
	logic [31:0] memWrData;
	logic        memWe;
	logic [7:0]  shutter;

	logic [31:0] mem [0:65535];
	logic [15:0] rdAddrQ;
	logic [15:0] xAddr [$];
	logic [31:0] xVal [$];
	logic [31:0] sVal [$];
	int          shutterIdx;
	logic [7:0]  lastShutter;
	logic        monitorOn;
	logic        lineSent;

	clockGen clockGen_inst (.clk_o(wClk));

	seqTop seqTop_inst (
		.wClk_i(wClk), .rst_i(rst),
		.startAddr_i(startAddr), .startTrig_i(startTrig), .stopTrig_i(stopTrig),
		.lineTrig_i(lineTrig), .pmt_i(pmt), .memRdData_i(memRdData),
		.busy_o(busy), .memAddr_o(memAddr), .memWrData_o(memWrData),
		.memWe_o(memWe), .shutter_o(shutter)
	);

	////////////////////////////////////////
	// Error handling and checks
	////////////////////////////////////////
	task automatic failRun(input string why);
		$display("ERROR: %s", why);
		$display("Simulation failed");
		$fatal(1, "run stopped");
	endtask

	task automatic checkEq(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
			$display("Simulation failed");
			$fatal(1, "run stopped");
		end
	endtask

	task automatic waitBusyLevel(input logic level, input string what);
		int n;
		n = 0;
		while (busy !== level)
		begin
			@(negedge wClk);
			n++;
			if (n > TIMEOUT)
				failRun({"busy_o did not ", what, " in time"});
		end
	endtask

	task automatic startRun(input logic [15:0] addr);
		@(negedge wClk);
		startAddr = addr;
		startTrig = 1'b1;
		@(negedge wClk);
		startTrig = 1'b0;
	endtask

	task automatic loadStim();
		int    fd;
		int    got;
		string line;
		byte   tag;
		logic [31:0] a;
		logic [31:0] b;
		fd = $fopen("sim/seq_stim.txt", "r");
		if (fd == 0)
			failRun("cannot open the stimulus file sim/seq_stim.txt");
		while (!$feof(fd))
		begin
			line = "";
			got = $fgets(line, fd);
			if (got > 0 && line.len() > 2 && line[0] != "#")
			begin
				a = '0;
				b = '0;
				got = $sscanf(line, "%c %h %h", tag, a, b);
				case (tag)
					"M": mem[a[15:0]] = b;
					"X":
					begin
						xAddr.push_back(a[15:0]);
						xVal.push_back(b);
					end
					"S": sVal.push_back(a);
					default: failRun({"unknown line in stimulus file: ", line});
				endcase
			end
		end
		$fclose(fd);
	endtask

	////////////////////////////////////////
	// Memory model, one cycle read latency
	////////////////////////////////////////
	always @(posedge wClk)
	begin
		if (memWe)
			mem[memAddr] = memWrData;
		rdAddrQ = memAddr;
	end

	always @(negedge wClk)
		memRdData = mem[rdAddrQ];

	// Shutter sequence follows the S lines
	always @(negedge wClk)
	begin
		if (monitorOn && shutter !== lastShutter)
		begin
			if (shutterIdx >= sVal.size())
				failRun("shutter output changed more often than expected");
			checkEq($sformatf("shutter value %0d", shutterIdx), sVal[shutterIdx],
				{24'h0, shutter});
			if (shutterIdx == sVal.size() - 1)
				checkEq("shutter after line trigger", 32'h1, {31'h0, lineSent});
			shutterIdx++;
			lastShutter = shutter;
		end
	end

	initial
	begin
		int n;
		rst        = 1'b1;
		startAddr  = '0;
		startTrig  = 1'b0;
		stopTrig   = 1'b0;
		lineTrig   = 1'b0;
		pmt        = 1'b1;	// Photon on every sample
		memRdData  = '0;
		rdAddrQ    = '0;
		shutterIdx = 0;
		lastShutter = 8'h00;
		monitorOn  = 1'b0;
		lineSent   = 1'b0;

		for (int a = 0; a < 65536; a++)
			mem[a[15:0]] = {~a[15:0], a[15:0]};	// Unwritten words stay recognizable
		loadStim();

		repeat (10) @(negedge wClk);
		rst = 1'b0;
		@(negedge wClk);
		checkEq("busy after reset", 32'h0, {31'h0, busy});
		checkEq("memWe after reset", 32'h0, {31'h0, memWe});
		checkEq("shutter after reset", 32'h0, {24'h0, shutter});
		monitorOn = 1'b1;

		// Main program
		startRun(MAIN_START);
		checkEq("busy after start", 32'h1, {31'h0, busy});

		n = 0;
		while (shutterIdx < sVal.size() - 1)
		begin
			@(negedge wClk);
			n++;
			if (n > TIMEOUT)
				failRun("shutter values before the line wait never appeared");
		end
		repeat (20) @(negedge wClk);
		checkEq("held at line wait", 32'(sVal.size() - 1), 32'(shutterIdx));
		lineTrig = 1'b1;
		lineSent = 1'b1;
		@(negedge wClk);
		lineTrig = 1'b0;

		waitBusyLevel(1'b0, "fall after STOP");
		checkEq("shutter count", 32'(sVal.size()), 32'(shutterIdx));
		foreach (xAddr[k])
			checkEq($sformatf("mem[%h]", xAddr[k]), xVal[k], mem[xAddr[k]]);

		////////////////////////////////////////
		// Stop trigger during a long delay
		////////////////////////////////////////
		startRun(HOLD_START);
		checkEq("busy after second start", 32'h1, {31'h0, busy});
		repeat (50) @(negedge wClk);
		checkEq("busy during delay", 32'h1, {31'h0, busy});
		stopTrig = 1'b1;
		@(negedge wClk);
		stopTrig = 1'b0;
		checkEq("busy after stop trigger", 32'h0, {31'h0, busy});

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim/seq_stim.txt ====
# M addr word : preload memory | X addr word : expected after STOP | S value : shutter order
# Word layout: opcode[31:24], direct flag[23], value or address below
M 0000 01000040
M 0001 19000041
M 0002 04000060
M 0003 29000041
M 0004 29800003
M 0005 04000061
M 0006 17000042
M 0007 23000000
M 0008 23000000
M 0009 25000000
M 000A 04000062
M 000B 33800004
M 000C 35800002
M 000D 04000063
M 000E 06000046
M 000F 03000000
M 0010 2180000D
M 0011 05000000
M 0012 3180000C
M 0013 03000000
M 0014 2180000D
M 0015 05000000
M 0016 24000000
M 0017 07000064
M 0018 01000048
M 0019 25000000
M 001A 09800000
M 001B 12000019
M 001C 198000A1
M 001D 04000065
M 001E 09800050
M 001F 14000022
M 0020 13000023
M 0021 04000066
M 0022 04000067
M 0023 15000025
M 0024 04000068
M 0025 098000A1
M 0026 16000028
M 0027 04000069
M 0028 1100002A
M 0029 0400006A
M 002A 0400006B
M 002B 5280003C
M 002C 52000049
M 002D 44000000
M 002E 528000A5
M 002F 42800014
M 0030 45800032
M 0031 0400006C
M 0032 FF000000
M 0040 00000064
M 0041 00000023
M 0042 000000F0
M 0043 11111111
M 0044 22222222
M 0046 00000043
M 0048 00000003
M 0049 000000C3
M 0080 42FFFFFF
M 0081 FF000000
X 0060 00000087
X 0061 00000061
X 0062 00000061
X 0063 00000184
X 0050 11111111
X 0051 22222222
X 0064 00000052
X 0065 000000A1
X 0066 FF990066
X 0067 FF980067
X 0068 FF970068
X 0069 FF960069
X 006A FF95006A
X 006B 000000A1
X 006C 00000032
S 3C
S C3
S A5

// ==== list.f ====
hdl/seqPkg.sv
hdl/memArbiter.sv
hdl/fetchUnit.sv
hdl/execUnit.sv
hdl/waitUnit.sv
hdl/seqTop.sv
sim/clockGen.sv
sim/seqTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= seqTb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation completed successfully

SRCS := $(wildcard hdl/*.sv) $(wildcard sim/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) list.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f list.f

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
